/* program.hex */
// one instruction word per line in hex, from address 0 upward, with its assembly after it
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
002081b3 // 08 add  x3, x1, x2
40208233 // 0c sub  x4, x1, x2
0020f2b3 // 10 and  x5, x1, x2
0020e333 // 14 or   x6, x1, x2
0020c3b3 // 18 xor  x7, x1, x2
00409413 // 1c slli x8, x1, 4
00708013 // 20 addi x0, x1, 7
00742423 // 24 sw   x7, 8(x8)
00842483 // 28 lw   x9, 8(x8)
00748463 // 2c beq  x9, x7, +8   taken
00100513 // 30 addi x10, x0, 1   skipped
00749463 // 34 bne  x9, x7, +8   not taken
00208463 // 38 beq  x1, x2, +8   not taken
00209463 // 3c bne  x1, x2, +8   taken
00200513 // 40 addi x10, x0, 2   skipped
008005ef // 44 jal  x11, +8
00300513 // 48 addi x10, x0, 3   skipped
05b00613 // 4c addi x12, x0, 0x5b
002606e7 // 50 jalr x13, 2(x12)  target 0x5d becomes 0x5c
00400513 // 54 addi x10, x0, 4   skipped
00500513 // 58 addi x10, x0, 5   skipped
00b68733 // 5c add  x14, x13, x11
0000006f // 60 jal  x0, 0        parks here

/* files.f */
riscv_pkg.sv
ctrl_if.sv
control_unit.sv
execute_unit.sv
reg_file.sv
fetch_unit.sv
data_mem.sv
riscv_top.sv
riscv_sva.sv
riscv_checker.sv
tb_riscv.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_riscv -o sim_riscv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_riscv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* tb_riscv.sv */
`timescale 1ns/1ps

module tb_riscv;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int          RUN_CYCLES   = 200;
    localparam int          WATCHDOG_NS  = (20 + RUN_CYCLES + 20) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'heb9;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    int          check_count;
    int          error_count;

    riscv_top uut (
        .clk         (clk),
        .reset_i     (reset),
        .pc_o        (pc),
        .wb_en_o     (wb_en),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata)
    );

    riscv_checker u_checker (
        .clk           (clk),
        .reset_i       (reset),
        .pc_i          (pc),
        .wb_en_i       (wb_en),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data),
        .mem_we_i      (mem_we),
        .mem_addr_i    (mem_addr),
        .mem_wdata_i   (mem_wdata),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        int unsigned extra_cycles;

        reset <= 1'b1;
        void'($urandom(SEED));
        extra_cycles = $urandom % 4; // a few more reset cycles
        repeat (RESET_CYCLES + extra_cycles) @(posedge clk);
        reset <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk); // program parks in its last jal long before this
        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 uut.u_sva.fail_count);
        if (error_count == 0 && uut.u_sva.fail_count == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not end within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* riscv_checker.sv */
`timescale 1ns/1ps

module riscv_checker (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic [riscv_pkg::XLEN-1:0]       pc_i,
    input  logic                             wb_en_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]       wb_data_i,
    input  logic                             mem_we_i,
    input  logic [riscv_pkg::XLEN-1:0]       mem_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]       mem_wdata_i,
    output int                               check_count_o,
    output int                               error_count_o
);

    logic [31:0] rom [riscv_pkg::IMEM_DEPTH];
    logic [31:0] xreg [32];                    // model registers, x0 is never written
    logic [31:0] dmem [riscv_pkg::DMEM_DEPTH];
    logic [31:0] model_pc;
    logic [31:0] exp_pc, exp_wb_data, exp_mem_addr, exp_mem_wdata;
    logic [4:0]  exp_wb_addr;
    logic        exp_wb_en, exp_mem_we;
    int          checks = 0;
    int          errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    initial begin
        $readmemh("program.hex", rom);
    end

    // executes the instruction at model_pc and records what the trace should show
    function automatic void step();
        logic [31:0] ins;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic        writes_rd;

        ins         = rom[model_pc[riscv_pkg::IMEM_AW+1:2]];
        rs1v        = xreg[ins[19:15]];
        rs2v        = xreg[ins[24:20]];
        addr        = rs1v + {{20{ins[31]}}, ins[31:20]}; // rs1 + i-type immediate
        next_pc     = model_pc + 32'd4;
        writes_rd   = 1'b0;
        exp_pc      = model_pc;
        exp_wb_data = next_pc;                            // link value for jal and jalr
        exp_mem_we  = 1'b0;
        case (ins[6:0])
            riscv_pkg::OP_IMM: begin
                writes_rd   = 1'b1;
                exp_wb_data = (ins[14:12] == 3'b001) ? rs1v << ins[24:20] : addr;
            end
            riscv_pkg::OP_REG: begin
                writes_rd = 1'b1;
                case (ins[14:12])
                    3'b000:  exp_wb_data = ins[30] ? rs1v - rs2v : rs1v + rs2v;
                    3'b100:  exp_wb_data = rs1v ^ rs2v;
                    3'b110:  exp_wb_data = rs1v | rs2v;
                    default: exp_wb_data = rs1v & rs2v;
                endcase
            end
            riscv_pkg::OP_LOAD: begin
                writes_rd   = 1'b1;
                exp_wb_data = dmem[addr[riscv_pkg::DMEM_AW+1:2]];
            end
            riscv_pkg::OP_STORE: begin
                exp_mem_we = 1'b1;
                addr       = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            riscv_pkg::OP_BRANCH: begin
                if (ins[12] ? (rs1v != rs2v) : (rs1v == rs2v)) begin // bne, beq
                    next_pc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            riscv_pkg::OP_JAL: begin
                writes_rd = 1'b1;
                next_pc   = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            riscv_pkg::OP_JALR: begin
                writes_rd = 1'b1;
                next_pc   = addr & ~32'h1;
            end
            default: ;
        endcase
        exp_wb_en     = writes_rd && ins[11:7] != 5'd0;  // a write to x0 is invisible
        exp_wb_addr   = ins[11:7];
        exp_mem_addr  = addr;
        exp_mem_wdata = rs2v;
        if (exp_wb_en) begin
            xreg[exp_wb_addr] = exp_wb_data;
        end
        if (exp_mem_we) begin
            dmem[addr[riscv_pkg::DMEM_AW+1:2]] = rs2v;
        end
        model_pc = next_pc;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // mid-cycle, so every trace output has settled
    always @(negedge clk) begin
        if (reset_i) begin
            model_pc = '0;
            for (int i = 0; i < 32; i++) begin
                xreg[i] = '0;
            end
            for (int i = 0; i < riscv_pkg::DMEM_DEPTH; i++) begin
                dmem[i] = '0;
            end
            check_field("pc_o", 32'h0, pc_i);
            check_field("wb_en_o", 32'h0, 32'(wb_en_i));
            check_field("mem_we_o", 32'h0, 32'(mem_we_i));
        end else begin
            step();
            check_field("pc_o", exp_pc, pc_i);
            check_field("wb_en_o", 32'(exp_wb_en), 32'(wb_en_i));
            check_field("mem_we_o", 32'(exp_mem_we), 32'(mem_we_i));
            if (exp_wb_en) begin
                check_field("wb_addr_o", 32'(exp_wb_addr), 32'(wb_addr_i));
                check_field("wb_data_o", exp_wb_data, wb_data_i);
            end
            if (exp_mem_we) begin
                check_field("mem_addr_o", exp_mem_addr, mem_addr_i);
                check_field("mem_wdata_o", exp_mem_wdata, mem_wdata_i);
            end
        end
    end

endmodule

/* riscv_sva.sv */
`timescale 1ns/1ps

module riscv_sva (
    input logic                             clk,
    input logic                             reset_i,
    input logic [riscv_pkg::XLEN-1:0]       pc_i,
    input logic                             wb_en_i,
    input logic [riscv_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input logic                             mem_we_i
);

    int fail_count = 0; // failed assertions so far

    pc_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else begin
            $error("pc_o left word alignment");
            fail_count++;
        end

    // a single instruction either writes a register or stores, never both
    wb_store_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(wb_en_i && mem_we_i))
        else begin
            $error("wb_en_o and mem_we_o high together");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (reset_i)
        wb_en_i |-> wb_addr_i != '0)
        else begin
            $error("wb_en_o raised for x0");
            fail_count++;
        end

    pc_after_reset: assert property (@(posedge clk) reset_i |=> pc_i == '0)
        else begin
            $error("pc_o not zero after reset");
            fail_count++;
        end

endmodule

bind riscv_top riscv_sva u_sva (
    .clk       (clk),
    .reset_i   (reset_i),
    .pc_i      (pc_o),
    .wb_en_i   (wb_en_o),
    .wb_addr_i (wb_addr_o),
    .mem_we_i  (mem_we_o)
);

/* riscv_top.sv */
`timescale 1ns/1ps

module riscv_top (
    input  logic                             clk,
    input  logic                             reset_i,
    output logic [riscv_pkg::XLEN-1:0]       pc_o,
    output logic                             wb_en_o,
    output logic [riscv_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [riscv_pkg::XLEN-1:0]       wb_data_o,
    output logic                             mem_we_o,
    output logic [riscv_pkg::XLEN-1:0]       mem_addr_o,
    output logic [riscv_pkg::XLEN-1:0]       mem_wdata_o
);

    logic [riscv_pkg::XLEN-1:0] instr;
    logic [riscv_pkg::XLEN-1:0] pc_plus4;
    logic [riscv_pkg::XLEN-1:0] imm;
    logic [riscv_pkg::XLEN-1:0] alu_result;
    logic [riscv_pkg::XLEN-1:0] rs1_data;
    logic [riscv_pkg::XLEN-1:0] rs2_data;
    logic [riscv_pkg::XLEN-1:0] mem_rdata;
    logic                       zero;

    ctrl_if ctrl_bus ();

    fetch_unit u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .ctrl         (ctrl_bus.datapath),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .pc_o         (pc_o),
        .pc_plus4_o   (pc_plus4),
        .instr_o      (instr)
    );

    control_unit u_ctrl (
        .instr_i (instr),
        .zero_i  (zero),      // same-cycle feedback from the alu
        .ctrl    (ctrl_bus.decoder)
    );

    reg_file u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (instr[19:15]),
        .rs2_addr_i (instr[24:20]),
        .rd_addr_i  (wb_addr_o),
        .rd_data_i  (wb_data_o),
        .we_i       (wb_en_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_unit u_exec (
        .instr_i      (instr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ctrl         (ctrl_bus.datapath),
        .imm_o        (imm),
        .alu_result_o (alu_result),
        .zero_o       (zero)
    );

    data_mem u_dmem (
        .clk     (clk),
        .addr_i  (alu_result),
        .wdata_i (rs2_data),
        .we_i    (mem_we_o),
        .rdata_o (mem_rdata)
    );

    // write-back select
    always_comb begin
        case (ctrl_bus.result_src)
            riscv_pkg::RES_MEM: wb_data_o = mem_rdata;
            riscv_pkg::RES_PC4: wb_data_o = pc_plus4; // link address
            default:            wb_data_o = alu_result;
        endcase
    end

    assign wb_addr_o = instr[11:7];

    // enables come from decoding address 0 during reset, so hold them low
    assign wb_en_o  = ctrl_bus.reg_write && (wb_addr_o != '0) && !reset_i;
    assign mem_we_o = ctrl_bus.mem_write && !reset_i;

    assign mem_addr_o  = alu_result;
    assign mem_wdata_o = rs2_data;

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem (
    input  logic                       clk,
    input  logic [riscv_pkg::XLEN-1:0] addr_i,
    input  logic [riscv_pkg::XLEN-1:0] wdata_i,
    input  logic                       we_i,
    output logic [riscv_pkg::XLEN-1:0] rdata_o
);

    logic [riscv_pkg::XLEN-1:0]    ram [riscv_pkg::DMEM_DEPTH];
    logic [riscv_pkg::DMEM_AW-1:0] word_addr;

    initial begin
        for (int i = 0; i < riscv_pkg::DMEM_DEPTH; i++) begin
            ram[i] = '0; // memory starts cleared
        end
    end

    assign word_addr = addr_i[riscv_pkg::DMEM_AW+1:2]; // byte offset ignored

    always_ff @(posedge clk) begin
        if (we_i) begin
            ram[word_addr] <= wdata_i;
        end
    end

    assign rdata_o = ram[word_addr];

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       reset_i,
    ctrl_if.datapath                   ctrl,
    input  logic [riscv_pkg::XLEN-1:0] imm_i,
    input  logic [riscv_pkg::XLEN-1:0] alu_result_i,
    output logic [riscv_pkg::XLEN-1:0] pc_o,
    output logic [riscv_pkg::XLEN-1:0] pc_plus4_o,
    output logic [riscv_pkg::XLEN-1:0] instr_o
);

    logic [riscv_pkg::XLEN-1:0] rom [riscv_pkg::IMEM_DEPTH];
    logic [riscv_pkg::XLEN-1:0] pc_next;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        case (ctrl.pc_src)
            riscv_pkg::PC_TARGET: pc_next = pc_o + imm_i;               // branch or jal
            riscv_pkg::PC_JALR:   pc_next = {alu_result_i[31:1], 1'b0}; // rs1 + imm, lsb cleared
            default:              pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= '0;
        end else begin
            pc_o <= pc_next;
        end
    end

    // word index into the rom
    assign instr_o = rom[pc_o[riscv_pkg::IMEM_AW+1:2]];

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]       rd_data_i,
    input  logic                             we_i,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data_o
);

    logic [riscv_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // combinational read, x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic [riscv_pkg::XLEN-1:0] instr_i,
    input  logic [riscv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [riscv_pkg::XLEN-1:0] rs2_data_i,
    ctrl_if.datapath                   ctrl,
    output logic [riscv_pkg::XLEN-1:0] imm_o,
    output logic [riscv_pkg::XLEN-1:0] alu_result_o,
    output logic                       zero_o
);

    logic [riscv_pkg::XLEN-1:0] src_b;

    // immediate extension, sign bit is always instr[31]
    always_comb begin
        case (ctrl.imm_src)
            riscv_pkg::IMM_I: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            riscv_pkg::IMM_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            riscv_pkg::IMM_B: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                       instr_i[30:25], instr_i[11:8], 1'b0};
            riscv_pkg::IMM_J: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                       instr_i[20], instr_i[30:21], 1'b0};
            default:          imm_o = '0;
        endcase
    end

    assign src_b = ctrl.alu_src ? imm_o : rs2_data_i;

    always_comb begin
        case (ctrl.alu_ctrl)
            riscv_pkg::ALU_ADD: alu_result_o = rs1_data_i + src_b;
            riscv_pkg::ALU_SUB: alu_result_o = rs1_data_i - src_b;
            riscv_pkg::ALU_AND: alu_result_o = rs1_data_i & src_b;
            riscv_pkg::ALU_OR:  alu_result_o = rs1_data_i | src_b;
            riscv_pkg::ALU_XOR: alu_result_o = rs1_data_i ^ src_b;
            riscv_pkg::ALU_SLL: alu_result_o = rs1_data_i << src_b[4:0]; // low five bits only
            default:            alu_result_o = '0;
        endcase
    end

    assign zero_o = (alu_result_o == '0); // beq/bne look at this after a sub

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic [riscv_pkg::XLEN-1:0] instr_i,
    input  logic                       zero_i,
    ctrl_if.decoder                    ctrl
);

    riscv_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic               funct7_b5;
    riscv_pkg::alu_op_e alu_op;

    assign opcode    = riscv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // alu op for the register and immediate classes
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == riscv_pkg::OP_REG && funct7_b5) begin
                    alu_op = riscv_pkg::ALU_SUB; // funct7 bit 5 only matters for reg-reg
                end else begin
                    alu_op = riscv_pkg::ALU_ADD;
                end
            end
            3'b001:  alu_op = riscv_pkg::ALU_SLL;
            3'b100:  alu_op = riscv_pkg::ALU_XOR;
            3'b110:  alu_op = riscv_pkg::ALU_OR;
            3'b111:  alu_op = riscv_pkg::ALU_AND;
            default: alu_op = riscv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        // no-op unless the opcode says otherwise
        ctrl.reg_write  = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.result_src = riscv_pkg::RES_ALU;
        ctrl.alu_ctrl   = riscv_pkg::ALU_ADD;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_src    = riscv_pkg::IMM_I;
        ctrl.pc_src     = riscv_pkg::PC_PLUS4;

        case (opcode)
            riscv_pkg::OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;            // base + offset
                ctrl.result_src = riscv_pkg::RES_MEM;
            end
            riscv_pkg::OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_src   = riscv_pkg::IMM_S;
            end
            riscv_pkg::OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_ctrl  = alu_op;
            end
            riscv_pkg::OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_ctrl  = alu_op;           // shamt sits in imm[4:0]
            end
            riscv_pkg::OP_BRANCH: begin
                ctrl.alu_ctrl = riscv_pkg::ALU_SUB; // compare by subtraction
                ctrl.imm_src  = riscv_pkg::IMM_B;
                if ((funct3 == 3'b000 && zero_i) || (funct3 == 3'b001 && !zero_i)) begin
                    ctrl.pc_src = riscv_pkg::PC_TARGET;
                end
            end
            riscv_pkg::OP_JAL: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = riscv_pkg::RES_PC4;
                ctrl.imm_src    = riscv_pkg::IMM_J;
                ctrl.pc_src     = riscv_pkg::PC_TARGET;
            end
            riscv_pkg::OP_JALR: begin
                ctrl.reg_write  = 1'b1;            // link register is written
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = riscv_pkg::RES_PC4;
                ctrl.pc_src     = riscv_pkg::PC_JALR;
            end
            default: begin
                ctrl.reg_write = 1'b0;             // unknown opcode, nothing commits
            end
        endcase
    end

endmodule

/* ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;

    logic                    reg_write;
    logic                    mem_write;
    riscv_pkg::result_sel_e  result_src;
    riscv_pkg::alu_op_e      alu_ctrl;
    logic                    alu_src;    // 1 selects the immediate as operand b
    riscv_pkg::imm_sel_e     imm_src;
    riscv_pkg::pc_sel_e      pc_src;

    modport decoder (
        output reg_write, mem_write, result_src, alu_ctrl,
        output alu_src, imm_src, pc_src
    );

    modport datapath (
        input reg_write, mem_write, result_src, alu_ctrl,
        input alu_src, imm_src, pc_src
    );

endinterface

/* riscv_pkg.sv */
package riscv_pkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    localparam int IMEM_DEPTH = 64; // rom words
    localparam int DMEM_DEPTH = 64; // ram words

    localparam int IMEM_AW = $clog2(IMEM_DEPTH); // rom word index width
    localparam int DMEM_AW = $clog2(DMEM_DEPTH); // ram word index width

    // major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011, // lw
        OP_STORE  = 7'b0100011, // sw
        OP_REG    = 7'b0110011, // add sub and or xor
        OP_IMM    = 7'b0010011, // addi slli
        OP_BRANCH = 7'b1100011, // beq bne
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // alu control encoding
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0, // loads, alu immediates, jalr
        IMM_S = 2'd1, // stores
        IMM_B = 2'd2, // branches with a 13-bit offset
        IMM_J = 2'd3  // jal with a 21-bit offset
    } imm_sel_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2  // link value for jal and jalr
    } result_sel_e;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'd0,
        PC_TARGET = 2'd1, // pc + imm
        PC_JALR   = 2'd2  // alu result with bit 0 cleared
    } pc_sel_e;

endpackage
